// File: verilog/scope_pkg.sv
package scope_pkg;

	//////////////////////////////////////////////////////////////////////
	// sample and trace widths
	//////////////////////////////////////////////////////////////////////

	// raw ADC sample
	localparam int SAMPLE_W = 12;
	// stored trace height, taken from the top of a sample
	localparam int PIX_W = 8;
	// channel order is a0, a1, b0, b1
	localparam int NUM_CH = 4;

	//////////////////////////////////////////////////////////////////////
	// grid and colours
	//////////////////////////////////////////////////////////////////////

	// vertical grid line where these low column bits are all ones
	localparam int GRID_X_BITS = 6;
	// horizontal grid line where these low row bits are zero
	localparam int GRID_Y_BITS = 5;

	localparam logic [23:0] COLOR_A0 = 24'hffffff;
	localparam logic [23:0] COLOR_A1 = 24'hff0000;
	localparam logic [23:0] COLOR_B0 = 24'h00ff00;
	localparam logic [23:0] COLOR_B1 = 24'h0000ff;
	localparam logic [23:0] COLOR_GRID = 24'h808080;

endpackage

// File: verilog/envelope_capture.sv
`timescale 1ns/1ps

module envelope_capture import scope_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic vsync,
	input  logic ad_strobe,
	input  logic [SAMPLE_W-1:0] ad_a0,
	input  logic [SAMPLE_W-1:0] ad_a1,
	input  logic [SAMPLE_W-1:0] ad_b0,
	input  logic [SAMPLE_W-1:0] ad_b1,
	output logic [NUM_CH-1:0][PIX_W-1:0] env_min,
	output logic [NUM_CH-1:0][PIX_W-1:0] env_max
);

	logic [NUM_CH-1:0][SAMPLE_W-1:0] sample;
	logic [NUM_CH-1:0][SAMPLE_W-1:0] run_min;
	logic [NUM_CH-1:0][SAMPLE_W-1:0] run_max;
	logic vsync_d;
	logic vsync_rise;
	logic pending;
	logic restart;

	// index 0 is a0, index 3 is b1
	assign sample = {ad_b1, ad_b0, ad_a1, ad_a0};

	assign vsync_rise = vsync & ~vsync_d;

	// the restart strobe is the first one at or after rising vsync
	assign restart = ad_strobe & (pending | vsync_rise);

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d <= 1'b0;
			pending <= 1'b0;
		end else begin
			vsync_d <= vsync;
			if (ad_strobe)
				pending <= 1'b0;
			else if (vsync_rise)
				pending <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// running envelope and frame latch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			run_min <= '0;
			run_max <= '0;
			env_min <= '0;
			env_max <= '0;
		end else if (restart) begin
			for (int k = 0; k < NUM_CH; k++) begin
				// hand the finished frame on, keep only the top bits
				env_min[k] <= run_min[k][SAMPLE_W-1 -: PIX_W];
				env_max[k] <= run_max[k][SAMPLE_W-1 -: PIX_W];
				// new frame starts from this sample
				run_min[k] <= sample[k];
				run_max[k] <= sample[k];
			end
		end else if (ad_strobe) begin
			for (int k = 0; k < NUM_CH; k++) begin
				if (sample[k] < run_min[k])
					run_min[k] <= sample[k];
				if (sample[k] > run_max[k])
					run_max[k] <= sample[k];
			end
		end
	end

	// a latched bar never turns upside down
	for (genvar k = 0; k < NUM_CH; k++) begin : g_env_chk
		assert property (@(posedge clk) disable iff (reset)
			restart |=> env_min[k] <= env_max[k]);
	end

endmodule

// File: verilog/column_buffer.sv
`timescale 1ns/1ps

module column_buffer import scope_pkg::*; #(
	parameter int COLUMNS = 800,
	parameter int BUF_DEPTH = 1024
) (
	input  logic clk,
	input  logic reset,
	input  logic vsync,
	input  logic [NUM_CH-1:0][PIX_W-1:0] env_min,
	input  logic [NUM_CH-1:0][PIX_W-1:0] env_max,
	input  logic [$clog2(COLUMNS)-1:0] col,
	output logic [NUM_CH-1:0][PIX_W-1:0] col_min,
	output logic [NUM_CH-1:0][PIX_W-1:0] col_max
);

	localparam int AW = $clog2(BUF_DEPTH);
	localparam int HALF_W = NUM_CH * PIX_W;
	localparam int WORD_W = 2 * HALF_W;

	logic [WORD_W-1:0] mem [BUF_DEPTH];
	logic [WORD_W-1:0] q;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	logic [AW:0] rd_sum;
	logic vsync_d;
	logic we;

	//////////////////////////////////////////////////////////////////////
	// write side, one column per frame
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d <= 1'b0;
			we <= 1'b0;
			wr_addr <= '0;
		end else begin
			vsync_d <= vsync;
			// falling vsync
			we <= vsync_d & ~vsync;
			if (we)
				wr_addr <= (wr_addr == AW'(BUF_DEPTH - 1)) ? '0 : wr_addr + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read side, scrolled so the newest column lands at COLUMNS-1
	//////////////////////////////////////////////////////////////////////

	// wr_addr - COLUMNS + col, kept positive by adding BUF_DEPTH first
	always_comb begin
		rd_sum = {1'b0, wr_addr} + (AW + 1)'(BUF_DEPTH - COLUMNS) + (AW + 1)'(col);
		if (rd_sum >= (AW + 1)'(BUF_DEPTH))
			rd_sum = rd_sum - (AW + 1)'(BUF_DEPTH);
	end

	always_ff @(posedge clk) begin
		if (reset)
			rd_addr <= '0;
		else
			rd_addr <= rd_sum[AW-1:0];
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= {env_max, env_min};
		q <= mem[rd_addr];
	end

	assign col_min = q[HALF_W-1:0];
	assign col_max = q[WORD_W-1 -: HALF_W];

	assert property (@(posedge clk) disable iff (reset) wr_addr < BUF_DEPTH);

endmodule

// File: verilog/trace_renderer.sv
`timescale 1ns/1ps

module trace_renderer import scope_pkg::*; #(
	parameter int COLUMNS = 800,
	parameter int TRACE_TOP = 224,
	parameter int LANE_PITCH = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic blank,
	input  logic vsync,
	output logic [$clog2(COLUMNS)-1:0] col,
	input  logic [NUM_CH-1:0][PIX_W-1:0] col_min,
	input  logic [NUM_CH-1:0][PIX_W-1:0] col_max,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	localparam int CW = $clog2(COLUMNS);
	// room for the lowest lane plus one spare bit against wrap
	localparam int ROW_W = $clog2(TRACE_TOP + NUM_CH * LANE_PITCH + (1 << PIX_W)) + 1;

	logic [ROW_W-1:0] row;
	logic [ROW_W-1:0] row_d1;
	logic [ROW_W-1:0] row_d2;
	logic [CW-1:0] col_d1;
	logic [CW-1:0] col_d2;
	logic [CW+GRID_X_BITS-1:0] col_ext;
	logic blank_d;
	logic in_scope;
	logic grid_hit;
	logic [NUM_CH-1:0] lane_hit;
	logic [23:0] rgb;

	//////////////////////////////////////////////////////////////////////
	// raster counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
			row <= '0;
			blank_d <= 1'b0;
		end else begin
			blank_d <= blank;
			col <= blank ? '0 : col + 1'b1;
			if (vsync)
				row <= '0;
			else if (blank & ~blank_d)
				row <= row + 1'b1;
		end
	end

	// match the two cycle buffer read
	always_ff @(posedge clk) begin
		if (reset) begin
			col_d1 <= '0;
			col_d2 <= '0;
			row_d1 <= '0;
			row_d2 <= '0;
		end else begin
			col_d1 <= col;
			col_d2 <= col_d1;
			row_d1 <= row;
			row_d2 <= row_d1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pixel tests
	//////////////////////////////////////////////////////////////////////

	assign in_scope = row_d2 >= ROW_W'(TRACE_TOP);

	// narrow screens have no vertical grid
	assign col_ext = col_d2;
	// the grid stays inside the scope area
	assign grid_hit = in_scope
		&& ((&col_ext[GRID_X_BITS-1:0]) || (row_d2[GRID_Y_BITS-1:0] == '0));

	for (genvar k = 0; k < NUM_CH; k++) begin : g_lane
		localparam int BASE = TRACE_TOP + k * LANE_PITCH;
		logic [ROW_W-1:0] offset;

		// height of this row above the lane base
		assign offset = row_d2 - ROW_W'(BASE);
		assign lane_hit[k] = (row_d2 >= ROW_W'(BASE))
			&& (offset >= ROW_W'(col_min[k]))
			&& (offset <= ROW_W'(col_max[k]));
	end

	// a0 wins over a1 over b0 over b1, grid last
	always_ff @(posedge clk) begin
		if (reset)
			rgb <= '0;
		else if (lane_hit[0])
			rgb <= COLOR_A0;
		else if (lane_hit[1])
			rgb <= COLOR_A1;
		else if (lane_hit[2])
			rgb <= COLOR_B0;
		else if (lane_hit[3])
			rgb <= COLOR_B1;
		else if (grid_hit)
			rgb <= COLOR_GRID;
		else
			rgb <= '0;
	end

	assign red = rgb[23:16];
	assign green = rgb[15:8];
	assign blue = rgb[7:0];

	// nothing is drawn above the scope area
	assert property (@(posedge clk) disable iff (reset)
		!in_scope |=> {red, green, blue} == 24'h000000);

endmodule

// File: verilog/vga_scope.sv
`timescale 1ns/1ps

module vga_scope import scope_pkg::*; #(
	parameter int COLUMNS = 800,
	parameter int BUF_DEPTH = 1024,
	parameter int TRACE_TOP = 224,
	parameter int LANE_PITCH = 32
) (
	input  logic clk,
	input  logic reset,
	input  logic blank,
	input  logic vsync,
	input  logic ad_strobe,
	input  logic [SAMPLE_W-1:0] ad_a0,
	input  logic [SAMPLE_W-1:0] ad_a1,
	input  logic [SAMPLE_W-1:0] ad_b0,
	input  logic [SAMPLE_W-1:0] ad_b1,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	localparam int COL_W = $clog2(COLUMNS);

	logic [NUM_CH-1:0][PIX_W-1:0] env_min;
	logic [NUM_CH-1:0][PIX_W-1:0] env_max;
	logic [NUM_CH-1:0][PIX_W-1:0] col_min;
	logic [NUM_CH-1:0][PIX_W-1:0] col_max;
	logic [COL_W-1:0] col;

	//////////////////////////////////////////////////////////////////////
	// capture, store, draw
	//////////////////////////////////////////////////////////////////////

	envelope_capture i_envelope_capture (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.ad_a0(ad_a0),
		.ad_a1(ad_a1),
		.ad_b0(ad_b0),
		.ad_b1(ad_b1),
		.env_min(env_min),
		.env_max(env_max)
	);

	column_buffer #(
		.COLUMNS(COLUMNS),
		.BUF_DEPTH(BUF_DEPTH)
	) i_column_buffer (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.env_min(env_min),
		.env_max(env_max),
		.col(col),
		.col_min(col_min),
		.col_max(col_max)
	);

	// three clocks from column count to pixel
	trace_renderer #(
		.COLUMNS(COLUMNS),
		.TRACE_TOP(TRACE_TOP),
		.LANE_PITCH(LANE_PITCH)
	) i_trace_renderer (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.col(col),
		.col_min(col_min),
		.col_max(col_max),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int HALF_PERIOD = 50
) (
	output logic clk
);

	initial clk = 1'b0;

	// 100 ns period with the default half period
	always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: tests/video_tasks.svh
`ifndef VIDEO_TASKS_SVH
`define VIDEO_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// raster drive and capture
//////////////////////////////////////////////////////////////////////

// one raster line; visible lines are also copied into screen
task automatic drive_line(input bit active, input int row);
	for (int s = 0; s < COLUMNS + GAP; s++) begin
		@(negedge clk);
		// column s-3 left the three stage pipeline at the last rising edge
		if (active && s >= 3 && s < COLUMNS + 3)
			screen[row][s-3] = {red, green, blue};
		blank = !(active && s < COLUMNS);
		ad_strobe = (s == 5) && (strobe_idx < n_strobes);
		if (ad_strobe) begin
			ad_a0 = samples[0][strobe_idx];
			ad_a1 = samples[1][strobe_idx];
			ad_b0 = samples[2][strobe_idx];
			ad_b1 = samples[3][strobe_idx];
			strobe_idx++;
		end
	end
endtask

task automatic wait_for_black(input int limit);
	int n;
	n = 0;
	while ({red, green, blue} != BLACK && n < limit) begin
		@(negedge clk);
		n++;
	end
	assert ({red, green, blue} == BLACK) else begin
		errors++;
		$display("timeout: picture still not black %0d clocks after vsync rose", limit);
	end
endtask

// vsync lines first, then the visible rows
task automatic run_frame();
	strobe_idx = 0;
	@(negedge clk);
	vsync = 1'b1;
	blank = 1'b1;
	wait_for_black(16);
	for (int v = 0; v < VS_LINES; v++)
		drive_line(1'b0, 0);
	vsync = 1'b0;
	for (int r = 0; r < LINES; r++)
		drive_line(1'b1, r);
endtask

// alternate lo and hi so the envelope spans both
task automatic set_channel(input int k, input logic [11:0] lo, input logic [11:0] hi);
	for (int i = 0; i < VS_LINES + LINES; i++)
		samples[k][i] = (i % 2 == 1) ? hi : lo;
endtask

//////////////////////////////////////////////////////////////////////
// pixel checks
//////////////////////////////////////////////////////////////////////

// want set: pixel must be colour, want clear: pixel must be anything else
task automatic check_colour(input int col, input int row, input logic [23:0] colour,
	input bit want);
	logic [23:0] actual;
	actual = screen[row][col];
	checks++;
	assert ((actual == colour) == want) else begin
		errors++;
		$display("MISMATCH at %0t: col %0d row %0d expected %s%06h actual %06h",
			$time, col, row, want ? "" : "not ", colour, actual);
	end
endtask

// a0 is white exactly on lane rows lo..hi
task automatic check_a0_bar(input int col, input int lo, input int hi);
	for (int r = 0; r < 256; r++)
		check_colour(col, TRACE_TOP + r, WHITE, r >= lo && r <= hi);
endtask

`endif

// File: tests/vga_scope_tb.sv
`timescale 1ns/1ps

module vga_scope_tb;

	localparam int COLUMNS = 16;
	localparam int BUF_DEPTH = 32;
	localparam int TRACE_TOP = 8;
	localparam int LANE_PITCH = 32;
	// tall enough for the whole a0 lane
	localparam int LINES = TRACE_TOP + 256 + 8;
	localparam int VS_LINES = 2;
	localparam int GAP = 4;

	localparam logic [23:0] WHITE = 24'hffffff;
	localparam logic [23:0] RED = 24'hff0000;
	localparam logic [23:0] GREEN = 24'h00ff00;
	localparam logic [23:0] BLUE = 24'h0000ff;
	localparam logic [23:0] GREY = 24'h808080;
	localparam logic [23:0] BLACK = 24'h000000;

	logic clk;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	logic [11:0] ad_a0;
	logic [11:0] ad_a1;
	logic [11:0] ad_b0;
	logic [11:0] ad_b1;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	logic [23:0] screen [LINES][COLUMNS];
	logic [11:0] samples [4][VS_LINES + LINES];
	int n_strobes;
	int strobe_idx;
	int errors;
	int checks;
	int tests_run;

	tb_clock i_tb_clock (.clk(clk));

	vga_scope #(
		.COLUMNS(COLUMNS),
		.BUF_DEPTH(BUF_DEPTH),
		.TRACE_TOP(TRACE_TOP),
		.LANE_PITCH(LANE_PITCH)
	) i_vga_scope (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.ad_a0(ad_a0),
		.ad_a1(ad_a1),
		.ad_b0(ad_b0),
		.ad_b1(ad_b1),
		.red(red),
		.green(green),
		.blue(blue)
	);

	`include "video_tasks.svh"

	function automatic logic [23:0] lane_colour(input int k);
		case (k)
			0: return WHITE;
			1: return RED;
			2: return GREEN;
			default: return BLUE;
		endcase
	endfunction

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("test %0d %s: %0d errors", tests_run, name, errors - start);
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_is_black();
		int start;
		start = errors;
		for (int n = 0; n < 8; n++) begin
			@(negedge clk);
			checks++;
			assert ({red, green, blue} == BLACK) else begin
				errors++;
				$display("MISMATCH at %0t: col 0 row 0 expected %06h actual %06h",
					$time, BLACK, {red, green, blue});
			end
		end
		report_test("black after reset", start);
	endtask

	task automatic constant_levels();
		int start;
		int bar;
		logic [11:0] lvl [4];
		start = errors;
		// all bars stay inside their own lane
		lvl = '{12'h0a5, 12'h137, 12'h0f0, 12'h1c9};
		for (int k = 0; k < 4; k++)
			set_channel(k, lvl[k], lvl[k]);
		n_strobes = 8;
		run_frame();
		n_strobes = 1;
		run_frame();
		for (int k = 0; k < 4; k++) begin
			bar = TRACE_TOP + k * LANE_PITCH + int'(lvl[k] >> 4);
			check_colour(COLUMNS - 1, bar, lane_colour(k), 1'b1);
			for (int d = -2; d <= 2; d++)
				if (d != 0)
					check_colour(COLUMNS - 1, bar + d, lane_colour(k), 1'b0);
		end
		report_test("constant levels", start);
	endtask

	task automatic random_bar();
		int start;
		int lo;
		int hi;
		start = errors;
		lo = 4095;
		hi = 0;
		for (int i = 0; i < 40; i++) begin
			for (int k = 0; k < 4; k++)
				samples[k][i] = 12'($urandom);
			if (int'(samples[0][i]) < lo)
				lo = int'(samples[0][i]);
			if (int'(samples[0][i]) > hi)
				hi = int'(samples[0][i]);
		end
		n_strobes = 40;
		run_frame();
		n_strobes = 1;
		run_frame();
		check_a0_bar(COLUMNS - 1, lo >> 4, hi >> 4);
		report_test("random a0 bar", start);
	endtask

	task automatic scroll_order();
		int start;
		logic [11:0] lvl [3];
		start = errors;
		lvl = '{12'h300, 12'h580, 12'h7f0};
		for (int k = 1; k < 4; k++)
			set_channel(k, 12'h000, 12'h000);
		for (int f = 0; f < 3; f++) begin
			set_channel(0, lvl[f], lvl[f]);
			n_strobes = 4;
			run_frame();
		end
		n_strobes = 1;
		run_frame();
		// oldest capture sits furthest left
		for (int f = 0; f < 3; f++)
			check_a0_bar(COLUMNS - 3 + f, int'(lvl[f] >> 4), int'(lvl[f] >> 4));
		report_test("scroll order", start);
	endtask

	task automatic priority_and_grid();
		int start;
		start = errors;
		// a0 on rows 40..55, a1 on rows 40..71
		set_channel(0, 12'h200, 12'h2ff);
		set_channel(1, 12'h000, 12'h1ff);
		set_channel(2, 12'h000, 12'h000);
		set_channel(3, 12'h000, 12'h000);
		n_strobes = 2;
		run_frame();
		n_strobes = 1;
		run_frame();
		check_colour(COLUMNS - 1, 48, WHITE, 1'b1);
		check_colour(COLUMNS - 1, 60, RED, 1'b1);
		check_colour(COLUMNS - 1, 72, GREEN, 1'b1);
		check_colour(COLUMNS - 1, 104, BLUE, 1'b1);
		check_colour(COLUMNS - 1, 96, GREY, 1'b1);
		check_colour(COLUMNS - 1, 128, GREY, 1'b1);
		check_colour(COLUMNS - 1, 97, BLACK, 1'b1);
		for (int r = 0; r < TRACE_TOP; r++)
			for (int c = 0; c < COLUMNS; c++)
				check_colour(c, r, BLACK, 1'b1);
		report_test("priority and grid", start);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		tests_run = 0;
		n_strobes = 0;
		strobe_idx = 0;
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b0;
		ad_strobe = 1'b0;
		ad_a0 = '0;
		ad_a1 = '0;
		ad_b0 = '0;
		ad_b1 = '0;
		void'($urandom(16));
		repeat (5) @(negedge clk);
		reset = 1'b0;

		reset_is_black();
		constant_levels();
		random_bar();
		scroll_order();
		priority_and_grid();

		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+tests
verilog/scope_pkg.sv
verilog/envelope_capture.sv
verilog/column_buffer.sv
verilog/trace_renderer.sv
verilog/vga_scope.sv
tests/tb_clock.sv
tests/vga_scope_tb.sv

// File: Makefile
SIM := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP := vga_scope_tb
FILELIST := src.f

BUILD_DIR := obj_dir
BIN := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
